// ==== bench/cluster_periph_assert.sv ====
//**************************************************************************
// Cluster peripheral protocol checks: read answer timing, cache instruction
// handshake and output levels right after reset
//**************************************************************************

`timescale 1ns/1ps

module cluster_periph_assert #(
  parameter int NR_CORES   = 4,
  parameter int SPM_SIZE_W = 8
) (
  input logic                  clk_i,
  input logic                  reset_i,
  input logic                  reg_req_i,
  input logic                  reg_write_i,
  input logic                  reg_rvalid_o,
  input logic [NR_CORES-1:0]   cl_clint_o,
  input logic                  icache_prefetch_enable_o,
  input logic                  cluster_probe_o,
  input logic [SPM_SIZE_W-1:0] l1d_spm_size_o,
  input logic                  l1d_insn_valid_o,
  input logic                  l1d_insn_ready_i
);

  int unsigned fail_count = 0;
  logic        wait_ready;

  // Issued instruction still waiting for its completion pulse
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wait_ready <= 1'b0;
    end else if (l1d_insn_valid_o) begin
      wait_ready <= 1'b1;
    end else if (l1d_insn_ready_i) begin
      wait_ready <= 1'b0;
    end
  end

  read_answer: assert property (@(posedge clk_i) disable iff (reset_i)
    reg_rvalid_o == $past(reg_req_i && !reg_write_i))
    else begin
      $error("read-valid strobe does not follow its read strobe by one cycle");
      fail_count++;
    end

  insn_single_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    l1d_insn_valid_o |=> !l1d_insn_valid_o)
    else begin
      $error("cache instruction valid held for two cycles");
      fail_count++;
    end

  insn_after_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    wait_ready |-> !l1d_insn_valid_o)
    else begin
      $error("cache instruction issued before completion of the previous one");
      fail_count++;
    end

  outputs_after_reset: assert property (@(posedge clk_i)
    $fell(reset_i) |-> (cl_clint_o == '0 && !icache_prefetch_enable_o &&
                        !cluster_probe_o && l1d_spm_size_o == '0 &&
                        !l1d_insn_valid_o && !reg_rvalid_o))
    else begin
      $error("control outputs not low after reset");
      fail_count++;
    end

endmodule

bind cluster_periph cluster_periph_assert #(
  .NR_CORES(NR_CORES), .SPM_SIZE_W(SPM_SIZE_W)
) u_chk (.*);

// ==== bench/cluster_periph_tb.sv ====
//**************************************************************************
// Cluster peripheral testbench driving register port stimulus, events and
// the cache handshake, with model based read checks
//**************************************************************************

`timescale 1ns/1ps

module cluster_periph_tb;

  localparam int TIMEOUT = 20;

  logic        clk_i = 1'b0;
  logic        reset_i;
  logic        reg_req_i;
  logic        reg_write_i;
  logic [11:0] reg_addr_i;
  logic [31:0] reg_wdata_i;
  logic        reg_rvalid_o;
  logic [31:0] reg_rdata_o;
  logic [9:0]  hart_base_id_i;
  logic [31:0] tcdm_start_addr_i;
  logic [31:0] tcdm_end_addr_i;
  logic [3:0][2:0] core_events_i;
  logic        tcdm_access_i;
  logic        tcdm_congest_i;
  logic        dma_busy_i;
  logic [3:0]  cl_clint_o;
  logic        icache_prefetch_enable_o;
  logic        cluster_probe_o;
  logic [7:0]  l1d_spm_size_o;
  logic [1:0]  l1d_insn_o;
  logic        l1d_insn_valid_o;
  logic        l1d_insn_ready_i;

  int errors = 0;
  int checks = 0;
  int tests  = 0;

  cluster_periph dut (.*);

  always #4 clk_i = ~clk_i;

  // All tasks start and end on a falling edge
  task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
    reg_req_i   = 1'b1;
    reg_write_i = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    @(negedge clk_i);
    reg_req_i = 1'b0;
  endtask

  task automatic read_reg(input logic [11:0] addr, output logic [31:0] data);
    int n;
    reg_req_i   = 1'b1;
    reg_write_i = 1'b0;
    reg_addr_i  = addr;
    @(negedge clk_i);
    reg_req_i = 1'b0;
    n = 0;
    while (!reg_rvalid_o && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (!reg_rvalid_o) begin
      $display("Read of address %h got no read-valid strobe", addr);
      errors++;
    end
    data = reg_rdata_o;
  endtask

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic expect_reg(input logic [11:0] addr, input logic [31:0] exp);
    logic [31:0] data;
    read_reg(addr, data);
    check($sformatf("register %h", addr), data, exp);
  endtask

  task automatic wait_insn_valid();
    int n;
    n = 0;
    while (!l1d_insn_valid_o && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (!l1d_insn_valid_o) begin
      $display("Cache instruction was never issued");
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("Test %-10s finished, errors so far %0d", name, errors);
  endtask

  // Expected register contents straight after reset
  function automatic logic [31:0] reset_value(input logic [11:0] addr);
    case (addr)
      cluster_periph_pkg::OFS_HART_BASE:  return 32'(hart_base_id_i);
      cluster_periph_pkg::OFS_TCDM_START: return tcdm_start_addr_i;
      cluster_periph_pkg::OFS_TCDM_END:   return tcdm_end_addr_i;
      default:                            return '0;
    endcase
  endfunction

  function automatic logic [11:0] perf_addr(input int idx, input int word);
    return cluster_periph_pkg::OFS_PERF_BASE +
           12'(idx * cluster_periph_pkg::OFS_PERF_STRIDE) + 12'(word * 4);
  endfunction

  function automatic logic [31:0] cfg_word(input logic [3:0] ev, input int hart, input bit en);
    logic [31:0] w;
    w = '0;
    w[cluster_periph_pkg::CFG_EN_BIT] = en;
    w[cluster_periph_pkg::CFG_EVENT_LSB +: 4] = ev;
    w[cluster_periph_pkg::CFG_HART_LSB +: 8] = hart[7:0];
    return w;
  endfunction

  initial begin
    logic [31:0] v;
    logic [3:0]  clint_m;
    logic [63:0] sum_acc;
    logic [63:0] sum_load;
    logic [63:0] cnt_exp;
    int          hart;
    void'($urandom(32'h1d6f));
    reset_i           = 1'b1;
    reg_req_i         = 1'b0;
    reg_write_i       = 1'b0;
    reg_addr_i        = '0;
    reg_wdata_i       = '0;
    hart_base_id_i    = 10'h2c5;
    tcdm_start_addr_i = $urandom;
    tcdm_end_addr_i   = $urandom;
    core_events_i     = '0;
    tcdm_access_i     = 1'b0;
    tcdm_congest_i    = 1'b0;
    dma_busy_i        = 1'b0;
    l1d_insn_ready_i  = 1'b0;
    repeat (10) @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);

    // Fixed map, counter window and a few unmapped holes
    check("outputs after reset", {cl_clint_o, icache_prefetch_enable_o, cluster_probe_o,
          l1d_spm_size_o, l1d_insn_valid_o}, '0);
    for (int a = 0; a < 'h40; a += 4) begin
      expect_reg(12'(a), reset_value(12'(a)));
    end
    for (int a = 'h100; a < 'h148; a += 4) begin
      expect_reg(12'(a), '0);
    end
    expect_reg(12'hffc, '0);
    finish_test("reset");

    clint_m = '0;
    for (int i = 0; i < 24; i++) begin
      v = $urandom;
      if (v[31]) begin
        write_reg(cluster_periph_pkg::OFS_CLINT_SET, v);
        clint_m = clint_m | v[3:0];
      end else begin
        write_reg(cluster_periph_pkg::OFS_CLINT_CLEAR, v);
        clint_m = clint_m & ~v[3:0];
      end
      check("wake-up outputs", cl_clint_o, clint_m);
      expect_reg(cluster_periph_pkg::OFS_CLINT_STATE, 32'(clint_m));
    end
    expect_reg(cluster_periph_pkg::OFS_CLINT_SET, '0);
    expect_reg(cluster_periph_pkg::OFS_CLINT_CLEAR, '0);
    for (int i = 0; i < 4; i++) begin
      v = $urandom;
      write_reg(cluster_periph_pkg::OFS_PREFETCH_EN, v);
      check("prefetch enable", icache_prefetch_enable_o, v[0]);
      write_reg(cluster_periph_pkg::OFS_PROBE, v >> 1);
      check("probe", cluster_probe_o, v[1]);
      expect_reg(cluster_periph_pkg::OFS_PREFETCH_EN, 32'(v[0]));
      expect_reg(cluster_periph_pkg::OFS_PROBE, 32'(v[1]));
    end
    finish_test("wake-up");

    // Counter 3 points at a hart that does not exist
    hart = $urandom_range(3, 0);
    write_reg(perf_addr(1, 0), cfg_word(cluster_periph_pkg::EV_TCDM_ACCESS, 0, 1'b1));
    write_reg(perf_addr(2, 0), cfg_word(cluster_periph_pkg::EV_RETIRED_LOAD, hart, 1'b1));
    write_reg(perf_addr(3, 0),
              cfg_word(cluster_periph_pkg::EV_ISSUE_FPU, 4 + $urandom_range(200, 0), 1'b1));
    sum_acc  = '0;
    sum_load = '0;
    for (int i = 0; i < 40; i++) begin
      v = $urandom;
      tcdm_access_i  = v[0];
      core_events_i  = v[12:1];
      tcdm_congest_i = v[13];
      dma_busy_i     = v[14];
      sum_acc  = sum_acc + v[0];
      sum_load = sum_load + core_events_i[hart][1];
      @(negedge clk_i);
    end
    // One extra access event pins down the two-edge counting delay
    tcdm_access_i  = 1'b1;
    core_events_i  = '0;
    tcdm_congest_i = 1'b0;
    dma_busy_i     = 1'b0;
    @(negedge clk_i);
    tcdm_access_i = 1'b0;
    expect_reg(perf_addr(1, 1), sum_acc[31:0]);
    sum_acc = sum_acc + 1;
    expect_reg(perf_addr(1, 1), sum_acc[31:0]);
    expect_reg(perf_addr(2, 1), sum_load[31:0]);
    expect_reg(perf_addr(3, 1), '0);

    // Cycle counter preloaded close to the low word limit
    write_reg(perf_addr(0, 1), 32'hffff_fffc);
    write_reg(perf_addr(0, 2), 32'h0000_0012);
    write_reg(perf_addr(0, 0), cfg_word(cluster_periph_pkg::EV_CYCLE, 0, 1'b1));
    repeat (5) @(negedge clk_i);
    write_reg(perf_addr(0, 0), cfg_word(cluster_periph_pkg::EV_CYCLE, 0, 1'b0));
    cnt_exp = 64'h12_ffff_fffc + 6;
    expect_reg(perf_addr(0, 1), cnt_exp[31:0]);
    expect_reg(perf_addr(0, 2), cnt_exp[63:32]);
    repeat (3) @(negedge clk_i);
    expect_reg(perf_addr(0, 1), cnt_exp[31:0]);
    expect_reg(perf_addr(0, 2), cnt_exp[63:32]);
    finish_test("counters");

    v = $urandom;
    write_reg(cluster_periph_pkg::OFS_L1D_SPM_CFG, v);
    expect_reg(cluster_periph_pkg::OFS_L1D_SPM_CFG, 32'(v[9:0]));
    write_reg(cluster_periph_pkg::OFS_L1D_SPM_COMMIT, 32'h1);
    check("size before latch", l1d_spm_size_o, 8'h00);
    @(negedge clk_i);
    check("scratchpad size", l1d_spm_size_o, v[7:0]);
    expect_reg(cluster_periph_pkg::OFS_L1D_SPM_COMMIT, '0);
    finish_test("spm");

    v = $urandom;
    write_reg(cluster_periph_pkg::OFS_L1D_INSN_CFG, v);
    write_reg(cluster_periph_pkg::OFS_L1D_INSN_COMMIT, 32'h1);
    wait_insn_valid();
    check("first instruction", l1d_insn_o, v[1:0]);
    @(negedge clk_i);
    check("instruction valid after issue", l1d_insn_valid_o, 1'b0);
    expect_reg(cluster_periph_pkg::OFS_L1D_FLUSH_STATUS, 32'h1);
    // Second commit has to wait for the cache
    write_reg(cluster_periph_pkg::OFS_L1D_INSN_CFG, v >> 2);
    write_reg(cluster_periph_pkg::OFS_L1D_INSN_COMMIT, 32'h1);
    expect_reg(cluster_periph_pkg::OFS_L1D_INSN_COMMIT, 32'h1);
    check("instruction valid while locked", l1d_insn_valid_o, 1'b0);
    repeat ($urandom_range(6, 2)) @(negedge clk_i);
    l1d_insn_ready_i = 1'b1;
    @(negedge clk_i);
    l1d_insn_ready_i = 1'b0;
    wait_insn_valid();
    check("second instruction", l1d_insn_o, v[3:2]);
    @(negedge clk_i);
    expect_reg(cluster_periph_pkg::OFS_L1D_INSN_COMMIT, '0);
    expect_reg(cluster_periph_pkg::OFS_L1D_FLUSH_STATUS, 32'h1);
    l1d_insn_ready_i = 1'b1;
    @(negedge clk_i);
    l1d_insn_ready_i = 1'b0;
    @(negedge clk_i);
    expect_reg(cluster_periph_pkg::OFS_L1D_FLUSH_STATUS, '0);
    finish_test("flush");

    errors = errors + dut.u_chk.fail_count;
    $display("%0d tests, %0d checks, %0d errors (%0d from assertions)",
             tests, checks, errors, dut.u_chk.fail_count);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== cluster_periph.f ====
common/cluster_periph_pkg.sv
hw/cluster_periph_regs/cluster_periph_regs.sv
hw/perf_counters/perf_counter_bank.sv
hw/l1d_cfg_ctrl.sv
hw/cluster_periph.sv
bench/cluster_periph_assert.sv
bench/cluster_periph_tb.sv

// ==== common/cluster_periph_pkg.sv ====
//**************************************************************************
// Cluster peripheral shared definitions: register map, counter config
// fields, event codes and field widths
//**************************************************************************

package cluster_periph_pkg;

  localparam int REG_DATA_W = 32;
  localparam int REG_ADDR_W = 12;
  localparam int HART_ID_W  = 10;

  // Fixed register map, byte offsets
  localparam logic [REG_ADDR_W-1:0] OFS_CLINT_SET        = 12'h000;
  localparam logic [REG_ADDR_W-1:0] OFS_CLINT_CLEAR      = 12'h004;
  localparam logic [REG_ADDR_W-1:0] OFS_CLINT_STATE      = 12'h008;
  localparam logic [REG_ADDR_W-1:0] OFS_PREFETCH_EN      = 12'h00C;
  localparam logic [REG_ADDR_W-1:0] OFS_PROBE            = 12'h010;
  localparam logic [REG_ADDR_W-1:0] OFS_HART_BASE        = 12'h014;
  localparam logic [REG_ADDR_W-1:0] OFS_TCDM_START       = 12'h018;
  localparam logic [REG_ADDR_W-1:0] OFS_TCDM_END         = 12'h01C;
  localparam logic [REG_ADDR_W-1:0] OFS_L1D_SPM_CFG      = 12'h020;
  localparam logic [REG_ADDR_W-1:0] OFS_L1D_SPM_COMMIT   = 12'h024;
  localparam logic [REG_ADDR_W-1:0] OFS_L1D_INSN_CFG     = 12'h028;
  localparam logic [REG_ADDR_W-1:0] OFS_L1D_INSN_COMMIT  = 12'h02C;
  localparam logic [REG_ADDR_W-1:0] OFS_L1D_FLUSH_STATUS = 12'h030;

  // Counter block: config at +0, value low at +4, value high at +8
  localparam logic [REG_ADDR_W-1:0] OFS_PERF_BASE   = 12'h100;
  localparam logic [REG_ADDR_W-1:0] OFS_PERF_STRIDE = 12'h010;

  // Counter config word fields
  localparam int CFG_EN_BIT    = 0;
  localparam int CFG_EVENT_LSB = 1;
  localparam int CFG_EVENT_W   = 4;
  localparam int CFG_HART_LSB  = 8;
  localparam int CFG_HART_W    = 8;

  localparam logic [CFG_EVENT_W-1:0] EV_CYCLE         = 4'd0;
  localparam logic [CFG_EVENT_W-1:0] EV_TCDM_ACCESS   = 4'd1;
  localparam logic [CFG_EVENT_W-1:0] EV_TCDM_CONGEST  = 4'd2;
  localparam logic [CFG_EVENT_W-1:0] EV_DMA_BUSY      = 4'd3;
  localparam logic [CFG_EVENT_W-1:0] EV_RETIRED_INSTR = 4'd4;
  localparam logic [CFG_EVENT_W-1:0] EV_RETIRED_LOAD  = 4'd5;
  localparam logic [CFG_EVENT_W-1:0] EV_ISSUE_FPU     = 4'd6;

  // Per-core event bits: retired instr, retired load, FPU issue
  localparam int CORE_EV_W = 3;

  localparam int SPM_CFG_W = 10;
  localparam int INSN_W    = 2;

endpackage

// ==== hw/cluster_periph.sv ====
//**************************************************************************
// Cluster peripheral top: register file, performance counters and
// L1 data-cache config control
//**************************************************************************

`timescale 1ns/1ps

module cluster_periph #(
  parameter int NR_CORES     = 4,
  parameter int NUM_COUNTERS = 4,
  parameter int COUNTER_W    = 48,
  parameter int TCDM_ADDR_W  = 32,
  parameter int SPM_SIZE_W   = 8
) (
  input  logic                                                   clk_i,
  input  logic                                                   reset_i,
  input  logic                                                   reg_req_i,
  input  logic                                                   reg_write_i,
  input  logic [cluster_periph_pkg::REG_ADDR_W-1:0]              reg_addr_i,
  input  logic [cluster_periph_pkg::REG_DATA_W-1:0]              reg_wdata_i,
  output logic                                                   reg_rvalid_o,
  output logic [cluster_periph_pkg::REG_DATA_W-1:0]              reg_rdata_o,
  input  logic [cluster_periph_pkg::HART_ID_W-1:0]               hart_base_id_i,
  input  logic [TCDM_ADDR_W-1:0]                                 tcdm_start_addr_i,
  input  logic [TCDM_ADDR_W-1:0]                                 tcdm_end_addr_i,
  input  logic [NR_CORES-1:0][cluster_periph_pkg::CORE_EV_W-1:0] core_events_i,
  input  logic                                                   tcdm_access_i,
  input  logic                                                   tcdm_congest_i,
  input  logic                                                   dma_busy_i,
  output logic [NR_CORES-1:0]                                    cl_clint_o,
  output logic                                                   icache_prefetch_enable_o,
  output logic                                                   cluster_probe_o,
  output logic [SPM_SIZE_W-1:0]                                  l1d_spm_size_o,
  output logic [cluster_periph_pkg::INSN_W-1:0]                  l1d_insn_o,
  output logic                                                   l1d_insn_valid_o,
  input  logic                                                   l1d_insn_ready_i
);

  logic [cluster_periph_pkg::SPM_CFG_W-1:0] spm_cfg;
  logic [cluster_periph_pkg::INSN_W-1:0]    insn_cfg;
  logic spm_commit, spm_commit_clr, insn_commit, insn_commit_clr, flush_busy;
  logic [NUM_COUNTERS-1:0][cluster_periph_pkg::REG_DATA_W-1:0] perf_cfg;
  logic [NUM_COUNTERS-1:0]                  perf_wr_en;
  logic                                     perf_wr_hi;
  logic [cluster_periph_pkg::REG_DATA_W-1:0] perf_wdata;
  logic [NUM_COUNTERS-1:0][COUNTER_W-1:0]   perf_value;

  cluster_periph_regs #(
    .NR_CORES(NR_CORES), .NUM_COUNTERS(NUM_COUNTERS),
    .COUNTER_W(COUNTER_W), .TCDM_ADDR_W(TCDM_ADDR_W)
  ) i_regs (
    .clk_i, .reset_i, .reg_req_i, .reg_write_i, .reg_addr_i, .reg_wdata_i,
    .reg_rvalid_o, .reg_rdata_o, .hart_base_id_i, .tcdm_start_addr_i, .tcdm_end_addr_i,
    .clint_o(cl_clint_o), .prefetch_en_o(icache_prefetch_enable_o), .probe_o(cluster_probe_o),
    .spm_cfg_o(spm_cfg), .spm_commit_o(spm_commit), .spm_commit_clr_i(spm_commit_clr),
    .insn_cfg_o(insn_cfg), .insn_commit_o(insn_commit), .insn_commit_clr_i(insn_commit_clr),
    .flush_busy_i(flush_busy), .perf_cfg_o(perf_cfg), .perf_wr_en_o(perf_wr_en),
    .perf_wr_hi_o(perf_wr_hi), .perf_wdata_o(perf_wdata), .perf_value_i(perf_value)
  );

  perf_counter_bank #(
    .NR_CORES(NR_CORES), .NUM_COUNTERS(NUM_COUNTERS), .COUNTER_W(COUNTER_W)
  ) i_perf (
    .clk_i, .reset_i, .core_events_i, .tcdm_access_i, .tcdm_congest_i, .dma_busy_i,
    .cfg_i(perf_cfg), .wr_en_i(perf_wr_en), .wr_hi_i(perf_wr_hi), .wdata_i(perf_wdata),
    .value_o(perf_value)
  );

  l1d_cfg_ctrl #(
    .SPM_SIZE_W(SPM_SIZE_W)
  ) i_l1d_ctrl (
    .clk_i, .reset_i, .spm_cfg_i(spm_cfg), .spm_commit_i(spm_commit),
    .spm_commit_clr_o(spm_commit_clr), .insn_cfg_i(insn_cfg), .insn_commit_i(insn_commit),
    .insn_commit_clr_o(insn_commit_clr), .l1d_insn_ready_i, .flush_busy_o(flush_busy),
    .l1d_spm_size_o, .l1d_insn_o, .l1d_insn_valid_o
  );

endmodule

// ==== hw/cluster_periph_regs/cluster_periph_regs.sv ====
//**************************************************************************
// Cluster peripheral register file: address decode, config registers,
// wake-up set/clear, L1D commit flags and registered read port
//**************************************************************************

`timescale 1ns/1ps

module cluster_periph_regs #(
  parameter int NR_CORES     = 4,
  parameter int NUM_COUNTERS = 4,
  parameter int COUNTER_W    = 48,
  parameter int TCDM_ADDR_W  = 32
) (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  logic                                          reg_req_i,
  input  logic                                          reg_write_i,
  input  logic [cluster_periph_pkg::REG_ADDR_W-1:0]     reg_addr_i,
  input  logic [cluster_periph_pkg::REG_DATA_W-1:0]     reg_wdata_i,
  output logic                                          reg_rvalid_o,
  output logic [cluster_periph_pkg::REG_DATA_W-1:0]     reg_rdata_o,
  input  logic [cluster_periph_pkg::HART_ID_W-1:0]      hart_base_id_i,
  input  logic [TCDM_ADDR_W-1:0]                        tcdm_start_addr_i,
  input  logic [TCDM_ADDR_W-1:0]                        tcdm_end_addr_i,
  output logic [NR_CORES-1:0]                           clint_o,
  output logic                                          prefetch_en_o,
  output logic                                          probe_o,
  output logic [cluster_periph_pkg::SPM_CFG_W-1:0]      spm_cfg_o,
  output logic                                          spm_commit_o,
  input  logic                                          spm_commit_clr_i,
  output logic [cluster_periph_pkg::INSN_W-1:0]         insn_cfg_o,
  output logic                                          insn_commit_o,
  input  logic                                          insn_commit_clr_i,
  input  logic                                          flush_busy_i,
  output logic [NUM_COUNTERS-1:0][cluster_periph_pkg::REG_DATA_W-1:0] perf_cfg_o,
  output logic [NUM_COUNTERS-1:0]                       perf_wr_en_o,
  output logic                                          perf_wr_hi_o,
  output logic [cluster_periph_pkg::REG_DATA_W-1:0]     perf_wdata_o,
  input  logic [NUM_COUNTERS-1:0][COUNTER_W-1:0]        perf_value_i
);

  logic wr, rd;
  logic [cluster_periph_pkg::REG_ADDR_W-1:0] perf_off, perf_idx;
  logic [1:0] perf_word;
  logic perf_hit;
  logic [63:0] perf_val_wide;
  logic [cluster_periph_pkg::REG_DATA_W-1:0] rdata_d;

  assign wr = reg_req_i & reg_write_i;
  assign rd = reg_req_i & ~reg_write_i;

  // Counter window decode
  assign perf_off  = reg_addr_i - cluster_periph_pkg::OFS_PERF_BASE;
  assign perf_idx  = perf_off >> $clog2(cluster_periph_pkg::OFS_PERF_STRIDE);
  assign perf_word = perf_off[3:2];
  assign perf_hit  = (reg_addr_i >= cluster_periph_pkg::OFS_PERF_BASE) &&
                     (perf_idx < NUM_COUNTERS);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      clint_o       <= '0;
      prefetch_en_o <= 1'b0;
      probe_o       <= 1'b0;
      spm_cfg_o     <= '0;
      insn_cfg_o    <= '0;
      perf_cfg_o    <= '0;
    end else if (wr) begin
      case (reg_addr_i)
        cluster_periph_pkg::OFS_CLINT_SET:    clint_o <= clint_o | reg_wdata_i[NR_CORES-1:0];
        cluster_periph_pkg::OFS_CLINT_CLEAR:  clint_o <= clint_o & ~reg_wdata_i[NR_CORES-1:0];
        cluster_periph_pkg::OFS_PREFETCH_EN:  prefetch_en_o <= reg_wdata_i[0];
        cluster_periph_pkg::OFS_PROBE:        probe_o <= reg_wdata_i[0];
        cluster_periph_pkg::OFS_L1D_SPM_CFG:
          spm_cfg_o <= reg_wdata_i[cluster_periph_pkg::SPM_CFG_W-1:0];
        cluster_periph_pkg::OFS_L1D_INSN_CFG:
          insn_cfg_o <= reg_wdata_i[cluster_periph_pkg::INSN_W-1:0];
        default: begin
          if (perf_hit && perf_word == 2'd0) begin
            perf_cfg_o[perf_idx] <= reg_wdata_i;
          end
        end
      endcase
    end
  end

  // Commit flags: hardware clear wins over a software set
  always_ff @(posedge clk_i) begin
    if (reset_i || spm_commit_clr_i) begin
      spm_commit_o <= 1'b0;
    end else if (wr && reg_addr_i == cluster_periph_pkg::OFS_L1D_SPM_COMMIT && reg_wdata_i[0]) begin
      spm_commit_o <= 1'b1;
    end
    if (reset_i || insn_commit_clr_i) begin
      insn_commit_o <= 1'b0;
    end else if (wr && reg_addr_i == cluster_periph_pkg::OFS_L1D_INSN_COMMIT && reg_wdata_i[0]) begin
      insn_commit_o <= 1'b1;
    end
  end

  // Value words go straight to the counter bank
  always_comb begin
    perf_wr_en_o = '0;
    for (int i = 0; i < NUM_COUNTERS; i++) begin
      perf_wr_en_o[i] = wr && perf_hit && (perf_idx == i) &&
                        (perf_word == 2'd1 || perf_word == 2'd2);
    end
  end
  assign perf_wr_hi_o = (perf_word == 2'd2);
  assign perf_wdata_o = reg_wdata_i;

  assign perf_val_wide = 64'(perf_value_i[perf_idx]);

  always_comb begin
    rdata_d = '0;
    case (reg_addr_i)
      cluster_periph_pkg::OFS_CLINT_STATE:      rdata_d[NR_CORES-1:0] = clint_o;
      cluster_periph_pkg::OFS_PREFETCH_EN:      rdata_d[0] = prefetch_en_o;
      cluster_periph_pkg::OFS_PROBE:            rdata_d[0] = probe_o;
      cluster_periph_pkg::OFS_HART_BASE:
        rdata_d[cluster_periph_pkg::HART_ID_W-1:0] = hart_base_id_i;
      cluster_periph_pkg::OFS_TCDM_START:       rdata_d[TCDM_ADDR_W-1:0] = tcdm_start_addr_i;
      cluster_periph_pkg::OFS_TCDM_END:         rdata_d[TCDM_ADDR_W-1:0] = tcdm_end_addr_i;
      cluster_periph_pkg::OFS_L1D_SPM_CFG:
        rdata_d[cluster_periph_pkg::SPM_CFG_W-1:0] = spm_cfg_o;
      cluster_periph_pkg::OFS_L1D_SPM_COMMIT:   rdata_d[0] = spm_commit_o;
      cluster_periph_pkg::OFS_L1D_INSN_CFG:
        rdata_d[cluster_periph_pkg::INSN_W-1:0] = insn_cfg_o;
      cluster_periph_pkg::OFS_L1D_INSN_COMMIT:  rdata_d[0] = insn_commit_o;
      cluster_periph_pkg::OFS_L1D_FLUSH_STATUS: rdata_d[0] = flush_busy_i;
      default: begin
        if (perf_hit) begin
          case (perf_word)
            2'd0:    rdata_d = perf_cfg_o[perf_idx];
            2'd1:    rdata_d = perf_val_wide[31:0];
            2'd2:    rdata_d = perf_val_wide[63:32];
            default: rdata_d = '0;
          endcase
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      reg_rvalid_o <= 1'b0;
    end else begin
      reg_rvalid_o <= rd;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd) begin
      reg_rdata_o <= rdata_d;
    end
  end

endmodule

// ==== hw/l1d_cfg_ctrl.sv ====
//**************************************************************************
// L1 data-cache config control: scratchpad size latch and a one-at-a-time
// flush/invalidate issue lock released by cache completion
//**************************************************************************

`timescale 1ns/1ps

module l1d_cfg_ctrl #(
  parameter int SPM_SIZE_W = 8
) (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  input  logic [cluster_periph_pkg::SPM_CFG_W-1:0] spm_cfg_i,
  input  logic                                     spm_commit_i,
  output logic                                     spm_commit_clr_o,
  input  logic [cluster_periph_pkg::INSN_W-1:0]    insn_cfg_i,
  input  logic                                     insn_commit_i,
  output logic                                     insn_commit_clr_o,
  input  logic                                     l1d_insn_ready_i,
  output logic                                     flush_busy_o,
  output logic [SPM_SIZE_W-1:0]                    l1d_spm_size_o,
  output logic [cluster_periph_pkg::INSN_W-1:0]    l1d_insn_o,
  output logic                                     l1d_insn_valid_o
);

  logic issue;

  // Size is taken one edge after the commit flag rises
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      l1d_spm_size_o <= '0;
    end else if (spm_commit_i) begin
      l1d_spm_size_o <= spm_cfg_i[SPM_SIZE_W-1:0];
    end
  end
  assign spm_commit_clr_o = spm_commit_i;

  // Pending commit waits while the cache is still busy
  assign issue             = insn_commit_i & ~flush_busy_o;
  assign l1d_insn_valid_o  = issue;
  assign l1d_insn_o        = issue ? insn_cfg_i : '0;
  assign insn_commit_clr_o = issue;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      flush_busy_o <= 1'b0;
    end else if (issue) begin
      flush_busy_o <= 1'b1;
    end else if (l1d_insn_ready_i) begin
      flush_busy_o <= 1'b0;
    end
  end

endmodule

// ==== hw/perf_counters/perf_counter_bank.sv ====
//**************************************************************************
// Performance counter bank with registered event inputs and per-counter
// event and hart selection
//**************************************************************************

`timescale 1ns/1ps

module perf_counter_bank #(
  parameter int NR_CORES     = 4,
  parameter int NUM_COUNTERS = 4,
  parameter int COUNTER_W    = 48
) (
  input  logic                                                      clk_i,
  input  logic                                                      reset_i,
  input  logic [NR_CORES-1:0][cluster_periph_pkg::CORE_EV_W-1:0]    core_events_i,
  input  logic                                                      tcdm_access_i,
  input  logic                                                      tcdm_congest_i,
  input  logic                                                      dma_busy_i,
  input  logic [NUM_COUNTERS-1:0][cluster_periph_pkg::REG_DATA_W-1:0] cfg_i,
  input  logic [NUM_COUNTERS-1:0]                                   wr_en_i,
  input  logic                                                      wr_hi_i,
  input  logic [cluster_periph_pkg::REG_DATA_W-1:0]                 wdata_i,
  output logic [NUM_COUNTERS-1:0][COUNTER_W-1:0]                    value_o
);

  logic [NR_CORES-1:0][cluster_periph_pkg::CORE_EV_W-1:0] core_events_q;
  logic tcdm_access_q, tcdm_congest_q, dma_busy_q;

  // One pipeline stage on all event inputs
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      core_events_q  <= '0;
      tcdm_access_q  <= 1'b0;
      tcdm_congest_q <= 1'b0;
      dma_busy_q     <= 1'b0;
    end else begin
      core_events_q  <= core_events_i;
      tcdm_access_q  <= tcdm_access_i;
      tcdm_congest_q <= tcdm_congest_i;
      dma_busy_q     <= dma_busy_i;
    end
  end

  for (genvar i = 0; i < NUM_COUNTERS; i++) begin : gen_cnt
    logic [cluster_periph_pkg::CFG_EVENT_W-1:0] ev_code;
    logic [cluster_periph_pkg::CFG_HART_W-1:0]  hart;
    logic [cluster_periph_pkg::CORE_EV_W-1:0]   hart_ev;
    logic                                       inc;
    logic [63:0]                                wr_val;
    logic [COUNTER_W-1:0]                       cnt_d;

    assign ev_code = cfg_i[i][cluster_periph_pkg::CFG_EVENT_LSB +: cluster_periph_pkg::CFG_EVENT_W];
    assign hart    = cfg_i[i][cluster_periph_pkg::CFG_HART_LSB +: cluster_periph_pkg::CFG_HART_W];

    always_comb begin
      hart_ev = '0;
      // Out-of-range hart counts nothing
      if (hart < NR_CORES) begin
        hart_ev = core_events_q[hart];
      end
      case (ev_code)
        cluster_periph_pkg::EV_CYCLE:         inc = 1'b1;
        cluster_periph_pkg::EV_TCDM_ACCESS:   inc = tcdm_access_q;
        cluster_periph_pkg::EV_TCDM_CONGEST:  inc = tcdm_congest_q;
        cluster_periph_pkg::EV_DMA_BUSY:      inc = dma_busy_q;
        cluster_periph_pkg::EV_RETIRED_INSTR: inc = hart_ev[0];
        cluster_periph_pkg::EV_RETIRED_LOAD:  inc = hart_ev[1];
        cluster_periph_pkg::EV_ISSUE_FPU:     inc = hart_ev[2];
        default:                              inc = 1'b0;
      endcase
    end

    always_comb begin
      // Software write replaces one 32-bit word and beats counting
      wr_val = 64'(value_o[i]);
      if (wr_hi_i) begin
        wr_val[63:32] = wdata_i;
      end else begin
        wr_val[31:0] = wdata_i;
      end
      cnt_d = value_o[i];
      if (wr_en_i[i]) begin
        cnt_d = wr_val[COUNTER_W-1:0];
      end else if (cfg_i[i][cluster_periph_pkg::CFG_EN_BIT]) begin
        cnt_d = value_o[i] + {{(COUNTER_W-1){1'b0}}, inc};
      end
    end

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        value_o[i] <= '0;
      end else begin
        value_o[i] <= cnt_d;
      end
    end
  end

endmodule
